// File: hw/perf_config.svh
////////////////////
// retire monitor configuration
// port count, counter width and the
// benchmark marker instruction words
////////////////////

`ifndef PERF_CONFIG_SVH
`define PERF_CONFIG_SVH

// instructions the core can retire per cycle
`define PERF_RETIRE_PORTS 2

// width of every class counter
`define PERF_COUNT_W 32

// addi x0, x0, 12 opens the window
`define PERF_START_NOP 32'h00C0_0013
// addi x0, x0, 13 closes it
`define PERF_END_NOP 32'h00D0_0013

`endif

// File: hw/perf_pkg.sv
////////////////////
// retire monitor types
// instruction views, opcode groups,
// mix categories and counter types
////////////////////

`default_nettype none

`include "perf_config.svh"

package perf_pkg;

    // rv32 major opcode groups, bits 6:2 of the word
    typedef enum logic [4:0] {
        ARITH     = 5'b01100,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JAL       = 5'b11011,
        JALR      = 5'b11001,
        LOAD      = 5'b00000,
        AMO       = 5'b01011,
        STORE     = 5'b01000,
        SYSTEM    = 5'b11100,
        FENCE     = 5'b00011
    } opcode_t;

    // field view of one instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
        logic [1:0] low;
    } rv_fields_t;

    // raw view for marker compare, field view for decode
    typedef union packed {
        logic [31:0] raw;
        rv_fields_t  fields;
    } instr_u;

    // counter index, also used as the read select
    typedef enum logic [2:0] {
        MIX_ALU,
        MIX_BR,
        MIX_MUL,
        MIX_DIV,
        MIX_LOAD,
        MIX_STORE,
        MIX_MISC,
        MIX_TOTAL
    } mix_cat_t;

    localparam int MIX_CLASSES = 7;
    localparam int MIX_CATS = 8;

    // one bit per class, total excluded
    typedef logic [MIX_CLASSES-1:0] mix_vec_t;

    typedef logic [`PERF_COUNT_W-1:0] count_t;

    // enough bits to hold every port hitting one class
    localparam int PORT_COUNT_W = $clog2(`PERF_RETIRE_PORTS + 1);
    typedef logic [PORT_COUNT_W-1:0] port_count_t;

endpackage

`default_nettype wire

// File: hw/retire_decoder.sv
////////////////////
// retire decoder
// spots the benchmark markers, classifies each
// retired instruction and sums the hits per
// class over all ports, one register stage
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "perf_config.svh"

module retire_decoder (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`PERF_RETIRE_PORTS-1:0] retire_valid,
    input  perf_pkg::instr_u           retire_instr [`PERF_RETIRE_PORTS],
    output perf_pkg::port_count_t      class_hits [perf_pkg::MIX_CATS],
    output logic                       start_seen,
    output logic                       end_seen
);
    import perf_pkg::*;

    logic [`PERF_RETIRE_PORTS-1:0] port_start;
    logic [`PERF_RETIRE_PORTS-1:0] port_end;
    logic [`PERF_RETIRE_PORTS-1:0] port_counted;
    mix_vec_t                      port_class [`PERF_RETIRE_PORTS];
    port_count_t                   hit_sum [MIX_CATS];

    // class of one instruction, unknown opcodes hit nothing
    function automatic mix_vec_t classify(input rv_fields_t f);
        mix_vec_t v;
        v = '0;
        case (f.opcode)
            ARITH: begin
                // M extension shares the opcode, funct7[0] marks it
                v[MIX_ALU] = ~f.funct7[0];
                v[MIX_MUL] = f.funct7[0] & ~f.funct3[2];
                v[MIX_DIV] = f.funct7[0] & f.funct3[2];
            end
            ARITH_IMM, AUIPC, LUI: v[MIX_ALU] = 1'b1;
            BRANCH, JAL, JALR:     v[MIX_BR] = 1'b1;
            LOAD:                  v[MIX_LOAD] = 1'b1;
            STORE:                 v[MIX_STORE] = 1'b1;
            AMO: begin
                // atomics both read and write memory
                v[MIX_LOAD] = 1'b1;
                v[MIX_STORE] = 1'b1;
            end
            SYSTEM, FENCE:         v[MIX_MISC] = 1'b1;
            default:               v = '0;
        endcase
        return v;
    endfunction

    ////////////////////
    // per port decode
    always_comb begin
        for (int p = 0; p < `PERF_RETIRE_PORTS; p++) begin
            port_start[p] = retire_valid[p] && (retire_instr[p].raw == `PERF_START_NOP);
            port_end[p] = retire_valid[p] && (retire_instr[p].raw == `PERF_END_NOP);
            // markers themselves never count
            port_counted[p] = retire_valid[p] && !port_start[p] && !port_end[p];
            port_class[p] = port_counted[p] ? classify(retire_instr[p].fields) : '0;
        end
    end

    ////////////////////
    // sum across ports
    always_comb begin
        for (int c = 0; c < MIX_CLASSES; c++) begin
            hit_sum[c] = '0;
            for (int p = 0; p < `PERF_RETIRE_PORTS; p++) begin
                hit_sum[c] = hit_sum[c] + port_count_t'(port_class[p][c]);
            end
        end
        hit_sum[MIX_TOTAL] = '0;
        for (int p = 0; p < `PERF_RETIRE_PORTS; p++) begin
            hit_sum[MIX_TOTAL] = hit_sum[MIX_TOTAL] + port_count_t'(port_counted[p]);
        end
    end

    // marker pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            start_seen <= 1'b0;
            end_seen <= 1'b0;
        end else begin
            start_seen <= |port_start;
            end_seen <= |port_end;
        end
    end

    // hit sums, only consumed while the window is open
    always_ff @(posedge clk) begin
        class_hits <= hit_sum;
    end

endmodule

`default_nettype wire

// File: hw/collection_window.sv
////////////////////
// collection window
// open on a start marker, closed on an end
// marker, with a counter clear on every start
////////////////////

`timescale 1ns/100ps
`default_nettype none

module collection_window (
    input  logic clk,
    input  logic rst,
    input  logic start_seen,
    input  logic end_seen,
    output logic counting,
    output logic clear
);

    ////////////////////
    // window state
    always_ff @(posedge clk) begin
        if (rst) begin
            counting <= 1'b0;
        end else if (start_seen) begin
            // start beats end when both land in one group
            counting <= 1'b1;
        end else if (end_seen) begin
            counting <= 1'b0;
        end
    end

    // counters zero at the start edge, so a rerun begins fresh
    assign clear = start_seen;

endmodule

`default_nettype wire

// File: hw/mix_counters.sv
////////////////////
// instruction mix counters
// one counter per class plus a total,
// accumulating registered hit sums while the
// window is open, read through a select mux
////////////////////

`timescale 1ns/100ps
`default_nettype none

module mix_counters (
    input  logic                  clk,
    input  logic                  rst,
    input  perf_pkg::port_count_t class_hits [perf_pkg::MIX_CATS],
    input  logic                  start_seen,
    input  logic                  end_seen,
    input  logic                  counting,
    input  logic                  clear,
    input  perf_pkg::mix_cat_t    count_sel,
    output perf_pkg::count_t      count_value
);
    import perf_pkg::*;

    count_t counts [MIX_CATS];
    logic   accumulate;

    // a group holding a marker is dropped whole
    assign accumulate = counting && !start_seen && !end_seen;

    ////////////////////
    // counters
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '{default: '0};
        end else if (clear) begin
            counts <= '{default: '0};
        end else if (accumulate) begin
            for (int c = 0; c < MIX_CATS; c++) begin
                counts[c] <= counts[c] + count_t'(class_hits[c]);
            end
        end
    end

    ////////////////////
    // read port
    assign count_value = counts[count_sel];

endmodule

`default_nettype wire

// File: hw/perf_monitor.sv
////////////////////
// retire trace performance monitor
// counts the retired instruction mix between
// the benchmark start and end markers
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "perf_config.svh"

module perf_monitor (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`PERF_RETIRE_PORTS-1:0] retire_valid,
    input  perf_pkg::instr_u              retire_instr [`PERF_RETIRE_PORTS],
    input  perf_pkg::mix_cat_t            count_sel,
    output perf_pkg::count_t              count_value,
    output logic                          collecting
);
    import perf_pkg::*;

    port_count_t class_hits [MIX_CATS];
    logic        start_seen;
    logic        end_seen;
    logic        counting;
    logic        clear;

    ////////////////////
    // decode stage
    retire_decoder retire_decoder_i (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .class_hits   (class_hits),
        .start_seen   (start_seen),
        .end_seen     (end_seen)
    );

    // window control
    collection_window collection_window_i (
        .clk        (clk),
        .rst        (rst),
        .start_seen (start_seen),
        .end_seen   (end_seen),
        .counting   (counting),
        .clear      (clear)
    );

    ////////////////////
    // counters and read mux
    mix_counters mix_counters_i (
        .clk         (clk),
        .rst         (rst),
        .class_hits  (class_hits),
        .start_seen  (start_seen),
        .end_seen    (end_seen),
        .counting    (counting),
        .clear       (clear),
        .count_sel   (count_sel),
        .count_value (count_value)
    );

    assign collecting = counting;

endmodule

`default_nettype wire

// File: tests/perf_monitor_props.sv
////////////////////
// perf monitor assertions
// window and counter rules, bound into the
// counter block where all window signals meet
////////////////////

`timescale 1ns/100ps
`default_nettype none

module perf_monitor_props (
    input logic             clk,
    input logic             rst,
    input logic             start_seen,
    input logic             counting,
    input logic             clear,
    input perf_pkg::count_t counts [perf_pkg::MIX_CATS]
);
    import perf_pkg::*;

    ////////////////////
    // counts hold while the window is shut and read zero after a clear
    for (genvar c = 0; c < MIX_CATS; c++) begin : g_count
        a_hold: assert property (@(posedge clk) disable iff (rst)
            (!counting && !clear) |=> $stable(counts[c]))
            else $error("counter %0d changed while the window was closed", c);

        a_clear: assert property (@(posedge clk) disable iff (rst)
            clear |=> (counts[c] == '0))
            else $error("counter %0d not zero after a clear", c);
    end

    // a start marker always leaves the window open
    a_start: assert property (@(posedge clk) disable iff (rst) start_seen |=> counting)
        else $error("window not open after a start marker");

    // window closed right after reset
    a_reset: assert property (@(posedge clk) $fell(rst) |-> !counting)
        else $error("window open in the first cycle after reset");

endmodule

bind mix_counters perf_monitor_props perf_monitor_props_i (
    .clk        (clk),
    .rst        (rst),
    .start_seen (start_seen),
    .counting   (counting),
    .clear      (clear),
    .counts     (counts)
);

`default_nettype wire

// File: tests/perf_monitor_tb.sv
////////////////////
// perf monitor testbench
// table of retire groups and counter reads,
// expected counts come from a reference model
////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "perf_config.svh"

module perf_monitor_tb;
    import perf_pkg::*;

    localparam int PORTS = `PERF_RETIRE_PORTS;
    localparam int HALF = 20;
    localparam int PERIOD = 2 * HALF;
    localparam int MAX_ROWS = 256;

    // sample encodings
    localparam logic [31:0] I_ADD = 32'h0031_00B3;
    localparam logic [31:0] I_ADDI = 32'h0010_8093;
    localparam logic [31:0] I_LUI = 32'h1234_52B7;
    localparam logic [31:0] I_AUIPC = 32'h0000_1317;
    localparam logic [31:0] I_BEQ = 32'h0020_8463;
    localparam logic [31:0] I_JAL = 32'h0100_00EF;
    localparam logic [31:0] I_JALR = 32'h0000_8067;
    localparam logic [31:0] I_MUL = 32'h0220_81B3;
    localparam logic [31:0] I_DIV = 32'h0220_C1B3;
    localparam logic [31:0] I_LW = 32'h0000_A203;
    localparam logic [31:0] I_SW = 32'h0040_A023;
    localparam logic [31:0] I_AMO = 32'h0020_A2AF;
    localparam logic [31:0] I_ECALL = 32'h0000_0073;
    localparam logic [31:0] I_FENCE = 32'h0FF0_000F;
    localparam logic [31:0] I_UNKNOWN = 32'h0000_007F;
    // addi with immediate bit 25 set
    localparam logic [31:0] I_ADDI_B25 = 32'h0200_0093;
    localparam logic [31:0] START = `PERF_START_NOP;
    localparam logic [31:0] STOP = `PERF_END_NOP;

    logic             clk;
    logic             rst;
    logic [PORTS-1:0] retire_valid;
    instr_u           retire_instr [PORTS];
    mix_cat_t         count_sel;
    count_t           count_value;
    logic             collecting;

    // stimulus table
    string            row_name [MAX_ROWS];
    bit               row_read [MAX_ROWS];
    logic [PORTS-1:0] row_valid [MAX_ROWS];
    logic [31:0]      row_word [MAX_ROWS][PORTS];
    mix_cat_t         row_sel [MAX_ROWS];
    count_t           row_count [MAX_ROWS];
    logic             row_flag [MAX_ROWS];
    int               num_rows;
    bit               table_ready;

    // reference model state
    count_t      model_counts [MIX_CATS];
    logic        model_open;
    logic [31:0] lfsr_state;
    int          count_errors;
    int          flag_errors;

    perf_monitor perf_monitor_i (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .count_sel    (count_sel),
        .count_value  (count_value),
        .collecting   (collecting)
    );

    always #HALF clk = ~clk;

    ////////////////////
    // checks
    task automatic check_count(input string name, input count_t expected, input count_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            count_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            flag_errors++;
        end
    endtask

    ////////////////////
    // filler words
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i] = lfsr_state[0];
        end
    endtask

    function automatic logic [4:0] group_op(input logic [3:0] idx);
        case (idx)
            4'd0: return ARITH;
            4'd1: return ARITH_IMM;
            4'd2: return AUIPC;
            4'd3: return LUI;
            4'd4: return BRANCH;
            4'd5: return JAL;
            4'd6: return JALR;
            4'd7: return LOAD;
            4'd8: return AMO;
            4'd9: return STORE;
            4'd10: return SYSTEM;
            4'd11: return FENCE;
            default: return 5'b11111;
        endcase
    endfunction

    // rd is never x0, so no filler word is a marker
    task automatic random_word(output logic [31:0] w);
        logic [31:0] pick;
        logic [31:0] f3;
        logic [31:0] m;
        take_bits(4, pick);
        take_bits(3, f3);
        take_bits(1, m);
        w = {6'b0, m[0], 5'd2, 5'd3, f3[2:0], 5'd1, group_op(pick[3:0]), 2'b11};
    endtask

    ////////////////////
    // reference model
    function automatic mix_vec_t ref_class(input logic [31:0] w);
        logic [4:0] op;
        logic       m_ext;
        logic       is_arith;
        mix_vec_t   v;
        op = w[6:2];
        m_ext = w[25];
        is_arith = (op == ARITH);
        v = '0;
        v[MIX_ALU] = (is_arith && !m_ext) || op == ARITH_IMM || op == AUIPC || op == LUI;
        v[MIX_MUL] = is_arith && m_ext && !w[14];
        v[MIX_DIV] = is_arith && m_ext && w[14];
        v[MIX_BR] = op == BRANCH || op == JAL || op == JALR;
        v[MIX_LOAD] = op == LOAD || op == AMO;
        v[MIX_STORE] = op == STORE || op == AMO;
        v[MIX_MISC] = op == SYSTEM || op == FENCE;
        return v;
    endfunction

    task automatic model_row(input int r);
        logic     has_start;
        logic     has_end;
        mix_vec_t v;
        has_start = 1'b0;
        has_end = 1'b0;
        for (int p = 0; p < PORTS; p++) begin
            has_start |= row_valid[r][p] && row_word[r][p] == START;
            has_end |= row_valid[r][p] && row_word[r][p] == STOP;
        end
        // a marker group is never counted, start wins over end
        if (has_start) begin
            model_open = 1'b1;
            model_counts = '{default: '0};
        end else if (has_end) begin
            model_open = 1'b0;
        end else if (model_open) begin
            for (int p = 0; p < PORTS; p++) begin
                if (row_valid[r][p]) begin
                    v = ref_class(row_word[r][p]);
                    for (int k = 0; k < MIX_CLASSES; k++) begin
                        model_counts[k] = model_counts[k] + count_t'(v[k]);
                    end
                    model_counts[MIX_TOTAL] = model_counts[MIX_TOTAL] + count_t'(1);
                end
            end
        end
    endtask

    ////////////////////
    // table building
    task automatic put_row(input string name, input bit read, input logic [PORTS-1:0] valid,
                           input logic [31:0] w0, input logic [31:0] w1);
        row_name[num_rows] = name;
        row_read[num_rows] = read;
        row_valid[num_rows] = valid;
        for (int p = 0; p < PORTS; p++) begin
            row_word[num_rows][p] = '0;
        end
        row_word[num_rows][0] = w0;
        row_word[num_rows][1] = w1;
        row_sel[num_rows] = MIX_ALU;
        row_count[num_rows] = '0;
        row_flag[num_rows] = 1'b0;
    endtask

    task automatic add_group(input string name, input logic [PORTS-1:0] valid,
                             input logic [31:0] w0, input logic [31:0] w1);
        put_row(name, 1'b0, valid, w0, w1);
        model_row(num_rows);
        num_rows++;
    endtask

    // drain the pipeline, then read every counter
    task automatic add_reads(input string name);
        for (int i = 0; i < 4; i++) begin
            add_group(name, '0, 32'h0, 32'h0);
        end
        for (int s = 0; s < MIX_CATS; s++) begin
            put_row(name, 1'b1, '0, 32'h0, 32'h0);
            row_sel[num_rows] = mix_cat_t'(s);
            row_count[num_rows] = model_counts[s];
            row_flag[num_rows] = model_open;
            num_rows++;
        end
    endtask

    task automatic build_table();
        logic [31:0] vbits;
        logic [31:0] w0;
        logic [31:0] w1;
        add_reads("after_reset");
        add_group("pre_start", 2'b11, I_ADD, I_LW);
        add_group("pre_start", 2'b01, I_MUL, I_ADD);
        add_group("pre_start", 2'b10, I_ADD, I_BEQ);
        add_reads("pre_start");
        // one per class on single ports
        add_group("one_per_class", 2'b01, START, 32'h0);
        add_group("one_per_class", 2'b01, I_ADD, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_ADDI);
        add_group("one_per_class", 2'b01, I_LUI, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_AUIPC);
        add_group("one_per_class", 2'b01, I_BEQ, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_JAL);
        add_group("one_per_class", 2'b01, I_JALR, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_MUL);
        add_group("one_per_class", 2'b01, I_DIV, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_LW);
        add_group("one_per_class", 2'b01, I_SW, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_AMO);
        add_group("one_per_class", 2'b01, I_ECALL, 32'h0);
        add_group("one_per_class", 2'b10, 32'h0, I_FENCE);
        add_reads("one_per_class");
        // both ports, with invalid slots
        add_group("multi_port", 2'b11, I_ADD, I_LW);
        add_group("multi_port", 2'b11, I_AMO, I_BEQ);
        add_group("multi_port", 2'b01, I_MUL, I_SW);
        add_group("multi_port", 2'b10, I_DIV, I_FENCE);
        add_group("multi_port", 2'b01, I_ADDI, STOP);
        add_group("multi_port", 2'b00, I_ADD, I_ADD);
        add_group("multi_port", 2'b11, I_JAL, I_ECALL);
        add_reads("multi_port");
        // marker groups
        add_group("after_end", 2'b11, I_ADD, STOP);
        add_group("after_end", 2'b11, I_LW, I_SW);
        add_reads("after_end");
        add_group("marker_group", 2'b11, START, I_MUL);
        add_group("marker_group", 2'b01, I_ADD, 32'h0);
        add_group("marker_group", 2'b11, START, STOP);
        add_group("marker_group", 2'b10, 32'h0, I_DIV);
        add_reads("marker_group");
        // rerun over filler words
        add_group("lfsr_rerun", 2'b01, START, 32'h0);
        for (int i = 0; i < 24; i++) begin
            take_bits(PORTS, vbits);
            random_word(w0);
            random_word(w1);
            add_group("lfsr_rerun", vbits[PORTS-1:0], w0, w1);
        end
        add_reads("lfsr_rerun");
        add_group("odd_words", 2'b01, START, 32'h0);
        add_group("odd_words", 2'b01, I_UNKNOWN, 32'h0);
        add_group("odd_words", 2'b10, 32'h0, I_ADDI_B25);
        add_reads("odd_words");
    endtask

    ////////////////////
    // main sequence
    initial begin
        mix_cat_t sel;
        clk = 1'b0;
        rst = 1'b1;
        retire_valid = '0;
        for (int p = 0; p < PORTS; p++) begin
            retire_instr[p].raw = '0;
        end
        count_sel = MIX_ALU;
        num_rows = 0;
        model_open = 1'b0;
        model_counts = '{default: '0};
        lfsr_state = 32'h57d6;
        count_errors = 0;
        flag_errors = 0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            @(negedge clk);
            retire_valid = row_valid[r];
            for (int p = 0; p < PORTS; p++) begin
                retire_instr[p].raw = row_word[r][p];
            end
            count_sel = row_sel[r];
            if (row_read[r]) begin
                // read in the low phase, between clock edges
                #(HALF / 2);
                sel = row_sel[r];
                check_count($sformatf("%s/%s", row_name[r], sel.name()), row_count[r],
                            count_value);
                check_flag($sformatf("%s/collecting", row_name[r]), row_flag[r], collecting);
            end
        end
        @(negedge clk);
        retire_valid = '0;
        $display("errors: %0d count mismatches, %0d flag mismatches", count_errors, flag_errors);
        if (count_errors + flag_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((num_rows + 3) * PERIOD + 40 * PERIOD);
        $display("the run timed out before all %0d table rows were applied", num_rows);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/perf_pkg.sv
hw/retire_decoder.sv
hw/collection_window.sv
hw/mix_counters.sv
hw/perf_monitor.sv
tests/perf_monitor_props.sv
tests/perf_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the perf monitor testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module perf_monitor_tb -Mdir obj_dir -o perf_monitor_sim \
        -f list.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/perf_monitor_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
